/* thread_pkg.sv */
// Thread controller shared definitions
// Thread count, thread index and mask types, PC type and the boot address
// of thread 0

`default_nettype none

package thread_pkg;

    // Hardware threads in the fetch stage
    parameter int NUM_TRD = 8;

    // Thread index, wide enough for NUM_TRD
    typedef logic [$clog2(NUM_TRD)-1:0] trd_id_t;

    // One bit per thread
    typedef logic [NUM_TRD-1:0] trd_mask_t;

    // Program counter
    typedef logic [31:0] pc_t;

    // Thread 0 starts here out of reset
    parameter pc_t DEFAULT_RESET_PC = 32'h0001_0100;

endpackage

`default_nettype wire

/* thread_table.sv */
// Thread status table
// Holds valid, running and parent per thread, finds the lowest free slot
// and applies create, kill, sleep and wake with the parent permission check

`timescale 1ns/1ps
`default_nettype none

module thread_table (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  create,      // New thread in lowest free slot
    input  logic                  kill,
    input  logic                  slp,
    input  logic                  wake,
    input  thread_pkg::trd_id_t   act_trd,     // Thread issuing the command
    input  thread_pkg::trd_id_t   obj_trd,     // Target of kill, slp, wake

    output thread_pkg::trd_mask_t valid_trd,
    output thread_pkg::trd_mask_t run_trd,
    output logic                  new_en,      // Accepted create this cycle
    output thread_pkg::trd_id_t   new_trd,     // Slot the next create takes
    output logic                  trd_full,
    output logic                  trd_of,      // Create with no free slot
    output logic                  invalid_op   // Refused kill, slp or wake
);

    thread_pkg::trd_id_t   parent_trd [thread_pkg::NUM_TRD];
    thread_pkg::trd_mask_t child_trd;   // Valid children of act_trd
    thread_pkg::trd_id_t   free_trd;
    logic                  op_cmd;
    logic                  op_ok;

    // Lowest invalid slot, scanned from the top so slot 0 wins
    always_comb begin
        free_trd = '0;
        for (int i = thread_pkg::NUM_TRD - 1; i >= 0; i--) begin
            if (!valid_trd[i]) begin
                free_trd = thread_pkg::trd_id_t'(i);
            end
        end
    end

    assign trd_full = &valid_trd;
    assign new_trd  = free_trd;
    assign new_en   = create && !trd_full;

    // Child relation of the acting thread
    always_comb begin
        for (int i = 0; i < thread_pkg::NUM_TRD; i++) begin
            child_trd[i] = valid_trd[i] && (parent_trd[i] == act_trd);
        end
    end

    // Create has priority over the other commands
    assign op_cmd = !create && (kill || slp || wake);
    // Acting on itself or on one of its own children only
    assign op_ok  = (obj_trd == act_trd) || child_trd[obj_trd];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_trd  <= thread_pkg::trd_mask_t'(1);   // Thread 0 boots running
            run_trd    <= thread_pkg::trd_mask_t'(1);
            trd_of     <= 1'b0;
            invalid_op <= 1'b0;
            for (int i = 0; i < thread_pkg::NUM_TRD; i++) begin
                parent_trd[i] <= '0;
            end
        end else begin
            trd_of     <= create && trd_full;
            invalid_op <= op_cmd && !op_ok;

            if (new_en) begin
                valid_trd[free_trd]  <= 1'b1;
                run_trd[free_trd]    <= 1'b1;
                parent_trd[free_trd] <= act_trd;
            end else if (op_cmd && op_ok) begin
                if (kill) begin
                    valid_trd[obj_trd] <= 1'b0;
                    run_trd[obj_trd]   <= 1'b0;
                end else if (slp) begin
                    run_trd[obj_trd] <= 1'b0;
                end else if (valid_trd[obj_trd]) begin
                    // A killed thread cannot be woken
                    run_trd[obj_trd] <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* thread_pc_file.sv */
// Per-thread program counter store
// Loads the start PC on create or a new PC on a write strobe, and presents
// the PC of the current thread combinationally

`timescale 1ns/1ps
`default_nettype none

module thread_pc_file #(
    parameter thread_pkg::pc_t RESET_PC = thread_pkg::DEFAULT_RESET_PC
) (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                new_en,     // Create accepted
    input  thread_pkg::trd_id_t new_trd,
    input  thread_pkg::pc_t     init_pc,

    input  logic                pc_wr,
    input  thread_pkg::trd_id_t pc_wr_trd,
    input  thread_pkg::pc_t     nxt_pc,

    input  thread_pkg::trd_id_t cur_trd,
    output thread_pkg::pc_t     cur_pc
);

    thread_pkg::pc_t pc_q [thread_pkg::NUM_TRD];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < thread_pkg::NUM_TRD; i++) begin
                pc_q[i] <= (i == 0) ? RESET_PC : '0;
            end
        end else begin
            for (int i = 0; i < thread_pkg::NUM_TRD; i++) begin
                if (new_en && (new_trd == thread_pkg::trd_id_t'(i))) begin
                    pc_q[i] <= init_pc;   // Create beats a same-slot write
                end else if (pc_wr && (pc_wr_trd == thread_pkg::trd_id_t'(i))) begin
                    pc_q[i] <= nxt_pc;
                end
            end
        end
    end

    // Read port for fetch
    assign cur_pc = pc_q[cur_trd];

endmodule

`default_nettype wire

/* thread_sched.sv */
// Round-robin thread scheduler
// Steps to the next running thread after the current one each cycle,
// holding on the current thread while atomic is high

`timescale 1ns/1ps
`default_nettype none

module thread_sched (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  atomic,    // Stay on the current thread
    input  thread_pkg::trd_mask_t run_trd,

    output thread_pkg::trd_id_t   cur_trd
);

    thread_pkg::trd_id_t nxt_trd;

    // Rotating priority search starting just after cur_trd
    always_comb begin
        thread_pkg::trd_id_t idx;
        logic                found;

        nxt_trd = cur_trd;
        found   = 1'b0;
        // Last step wraps back onto cur_trd itself
        for (int k = 1; k <= thread_pkg::NUM_TRD; k++) begin
            idx = cur_trd + thread_pkg::trd_id_t'(k);
            if (!found && run_trd[idx]) begin
                nxt_trd = idx;
                found   = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_trd <= '0;
        end else if (!atomic) begin
            cur_trd <= nxt_trd;   // Nothing running keeps cur_trd
        end
    end

endmodule

`default_nettype wire

/* thread_ctrl.sv */
// Thread controller of the multithreaded fetch stage
// Thread table, PC store and round-robin scheduler for eight hardware
// threads, presenting the current thread and its PC to fetch

`timescale 1ns/1ps
`default_nettype none

module thread_ctrl #(
    parameter thread_pkg::pc_t RESET_PC = thread_pkg::DEFAULT_RESET_PC
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // Command strobes, one taken per edge
    input  logic                  create,
    input  logic                  kill,
    input  logic                  slp,
    input  logic                  wake,
    input  thread_pkg::trd_id_t   act_trd,
    input  thread_pkg::trd_id_t   obj_trd,
    input  thread_pkg::pc_t       init_pc,    // Start PC for create

    input  logic                  atomic,

    // PC write port
    input  logic                  pc_wr,
    input  thread_pkg::trd_id_t   pc_wr_trd,
    input  thread_pkg::pc_t       nxt_pc,

    output thread_pkg::trd_id_t   cur_trd,
    output thread_pkg::trd_id_t   new_trd,
    output thread_pkg::trd_mask_t valid_trd,
    output thread_pkg::trd_mask_t run_trd,
    output logic                  trd_full,
    output logic                  trd_of,
    output logic                  invalid_op,
    output thread_pkg::pc_t       cur_pc
);

    logic new_en;   // Create accepted, loads init_pc

    thread_table u_table (
        .clk        (clk),
        .rst_n      (rst_n),
        .create     (create),
        .kill       (kill),
        .slp        (slp),
        .wake       (wake),
        .act_trd    (act_trd),
        .obj_trd    (obj_trd),
        .valid_trd  (valid_trd),
        .run_trd    (run_trd),
        .new_en     (new_en),
        .new_trd    (new_trd),
        .trd_full   (trd_full),
        .trd_of     (trd_of),
        .invalid_op (invalid_op)
    );

    thread_pc_file #(
        .RESET_PC (RESET_PC)
    ) u_pc (
        .clk       (clk),
        .rst_n     (rst_n),
        .new_en    (new_en),
        .new_trd   (new_trd),
        .init_pc   (init_pc),
        .pc_wr     (pc_wr),
        .pc_wr_trd (pc_wr_trd),
        .nxt_pc    (nxt_pc),
        .cur_trd   (cur_trd),
        .cur_pc    (cur_pc)
    );

    // Scheduler sees the pre-edge run mask
    thread_sched u_sched (
        .clk     (clk),
        .rst_n   (rst_n),
        .atomic  (atomic),
        .run_trd (run_trd),
        .cur_trd (cur_trd)
    );

endmodule

`default_nettype wire

/* thread_ctrl_props.sv */
// Concurrent checks on the thread controller
// Run bits only on valid threads, exclusive error pulses and legal
// scheduler moves, bound into the top level

`timescale 1ns/1ps
`default_nettype none

module thread_ctrl_props (
    input logic                  clk,
    input logic                  rst_n,
    input thread_pkg::trd_mask_t valid_trd,
    input thread_pkg::trd_mask_t run_trd,
    input logic                  trd_of,
    input logic                  invalid_op,
    input thread_pkg::trd_id_t   cur_trd
);

    // A run bit without its valid bit means a dead thread still scheduled
    run_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        (run_trd & ~valid_trd) == '0
    ) else $error("run_trd %h has a bit outside valid_trd %h", run_trd, valid_trd);

    one_error_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(trd_of && invalid_op)
    ) else $error("trd_of and invalid_op high in the same cycle");

    // New thread comes from the run mask seen before the edge
    sched_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        (cur_trd != $past(cur_trd)) |->
            ((thread_pkg::trd_mask_t'(1) << cur_trd) & $past(run_trd)) != '0
    ) else $error("cur_trd moved to thread %0d which was not running", cur_trd);

endmodule

// Table and scheduler outputs meet at the top level ports
bind thread_ctrl thread_ctrl_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid_trd  (valid_trd),
    .run_trd    (run_trd),
    .trd_of     (trd_of),
    .invalid_op (invalid_op),
    .cur_trd    (cur_trd)
);

`default_nettype wire

/* tb_thread_ctrl.sv */
// Testbench for the thread controller
// Replays the stimulus file one cycle per line, with random idle cycles
// where allowed, and checks the outputs after each sampling edge

`timescale 1ns/1ps
`default_nettype none

module tb_thread_ctrl;

    localparam string STIM_FILE   = "thread_ctrl_stimulus.txt";
    localparam int    NUM_FIELDS  = 18;
    localparam int    MAX_LINES   = 1000;
    localparam int    TIMEOUT_CYC = 2000;
    localparam int    RESET_CYC   = 16;
    localparam int    PEND_NONE   = 0;
    localparam int    PEND_FULL   = 1;   // All outputs checked
    localparam int    PEND_IDLE   = 2;   // Only valid and run checked

    logic                  clk;
    logic                  rst_n;
    logic                  create;
    logic                  kill;
    logic                  slp;
    logic                  wake;
    thread_pkg::trd_id_t   act_trd;
    thread_pkg::trd_id_t   obj_trd;
    thread_pkg::pc_t       init_pc;
    logic                  atomic;
    logic                  pc_wr;
    thread_pkg::trd_id_t   pc_wr_trd;
    thread_pkg::pc_t       nxt_pc;

    thread_pkg::trd_id_t   cur_trd;
    thread_pkg::trd_id_t   new_trd;
    thread_pkg::trd_mask_t valid_trd;
    thread_pkg::trd_mask_t run_trd;
    logic                  trd_full;
    logic                  trd_of;
    logic                  invalid_op;
    thread_pkg::pc_t       cur_pc;

    // Expected state after the edge that samples the last driven cycle
    int                    pend_mode;
    thread_pkg::trd_mask_t exp_valid;
    thread_pkg::trd_mask_t exp_run;
    thread_pkg::trd_id_t   exp_cur;
    thread_pkg::pc_t       exp_pc;
    logic                  exp_of;
    logic                  exp_inv;

    int                    err_cnt;
    int                    check_cnt;
    int                    data_cnt;
    logic [31:0]           fld [NUM_FIELDS];   // Columns of one stimulus line

    thread_ctrl u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .create     (create),
        .kill       (kill),
        .slp        (slp),
        .wake       (wake),
        .act_trd    (act_trd),
        .obj_trd    (obj_trd),
        .init_pc    (init_pc),
        .atomic     (atomic),
        .pc_wr      (pc_wr),
        .pc_wr_trd  (pc_wr_trd),
        .nxt_pc     (nxt_pc),
        .cur_trd    (cur_trd),
        .new_trd    (new_trd),
        .valid_trd  (valid_trd),
        .run_trd    (run_trd),
        .trd_full   (trd_full),
        .trd_of     (trd_of),
        .invalid_op (invalid_op),
        .cur_pc     (cur_pc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Watchdog for the whole run
    initial begin
        for (int i = 0; i < TIMEOUT_CYC; i++) begin
            @(posedge clk);
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
        $display("TESTS FAILED");
        $finish;
    end

    // Index of the lowest clear bit of a valid mask
    function automatic thread_pkg::trd_id_t lowest_free(input thread_pkg::trd_mask_t mask);
        thread_pkg::trd_id_t slot;
        slot = '0;
        for (int i = 0; i < thread_pkg::NUM_TRD; i++) begin
            if (!mask[i]) begin
                slot = thread_pkg::trd_id_t'(i);
                break;
            end
        end
        return slot;
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp_v,
                                input logic [31:0] got_v);
        err_cnt++;
        $display("Fail at time %0t: %s expected %h, got %h", $time, name, exp_v, got_v);
    endtask

    task automatic check_pending;
        if (pend_mode != PEND_NONE) begin
            check_cnt++;
            if (valid_trd !== exp_valid) report_value("valid_trd", 32'(exp_valid), 32'(valid_trd));
            if (run_trd !== exp_run) report_value("run_trd", 32'(exp_run), 32'(run_trd));
            if (pend_mode == PEND_FULL) begin
                // Full when every slot is valid
                if (trd_full !== (&exp_valid)) begin
                    report_value("trd_full", 32'(&exp_valid), 32'(trd_full));
                end
                // Next create lands in the lowest free slot
                if (!(&exp_valid) && new_trd !== lowest_free(exp_valid)) begin
                    report_value("new_trd", 32'(lowest_free(exp_valid)), 32'(new_trd));
                end
                if (cur_trd !== exp_cur) report_value("cur_trd", 32'(exp_cur), 32'(cur_trd));
                if (cur_pc !== exp_pc) report_value("cur_pc", exp_pc, cur_pc);
                if (trd_of !== exp_of) report_value("trd_of", 32'(exp_of), 32'(trd_of));
                if (invalid_op !== exp_inv) begin
                    report_value("invalid_op", 32'(exp_inv), 32'(invalid_op));
                end
            end
        end
    endtask

    // No command, scheduler held, so nothing may change
    task automatic idle_cycle;
        @(posedge clk);
        create <= 1'b0;
        kill   <= 1'b0;
        slp    <= 1'b0;
        wake   <= 1'b0;
        atomic <= 1'b1;
        pc_wr  <= 1'b0;
        @(negedge clk);
        check_pending();
        pend_mode = PEND_IDLE;
    endtask

    task automatic line_cycle;
        @(posedge clk);
        create    <= fld[1][0];
        kill      <= fld[2][0];
        slp       <= fld[3][0];
        wake      <= fld[4][0];
        act_trd   <= thread_pkg::trd_id_t'(fld[5]);
        obj_trd   <= thread_pkg::trd_id_t'(fld[6]);
        init_pc   <= fld[7];
        atomic    <= fld[8][0];
        pc_wr     <= fld[9][0];
        pc_wr_trd <= thread_pkg::trd_id_t'(fld[10]);
        nxt_pc    <= fld[11];
        @(negedge clk);
        check_pending();
        exp_valid = thread_pkg::trd_mask_t'(fld[12]);
        exp_run   = thread_pkg::trd_mask_t'(fld[13]);
        exp_cur   = thread_pkg::trd_id_t'(fld[14]);
        exp_pc    = fld[15];
        exp_of    = fld[16][0];
        exp_inv   = fld[17][0];
        pend_mode = PEND_FULL;
    endtask

    initial begin
        int    fd;
        int    n_fields;
        int    n_idle;
        int    line_no;
        string line_s;

        rst_n     = 1'b0;
        create    = 1'b0;
        kill      = 1'b0;
        slp       = 1'b0;
        wake      = 1'b0;
        act_trd   = '0;
        obj_trd   = '0;
        init_pc   = '0;
        atomic    = 1'b0;
        pc_wr     = 1'b0;
        pc_wr_trd = '0;
        nxt_pc    = '0;
        err_cnt   = 0;
        check_cnt = 0;
        data_cnt  = 0;
        line_no   = 0;
        void'($urandom(32'hbee8));

        for (int i = 0; i < RESET_CYC; i++) begin
            @(posedge clk);
        end
        rst_n <= 1'b1;

        // Thread 0 boots valid and running
        pend_mode = PEND_FULL;
        exp_valid = thread_pkg::trd_mask_t'(1);
        exp_run   = thread_pkg::trd_mask_t'(1);
        exp_cur   = '0;
        exp_pc    = thread_pkg::DEFAULT_RESET_PC;
        exp_of    = 1'b0;
        exp_inv   = 1'b0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            err_cnt++;
            $display("Error: cannot open stimulus file %s", STIM_FILE);
        end else begin
            while (line_no < MAX_LINES && $fgets(line_s, fd) != 0) begin
                line_no++;
                n_fields = $sscanf(line_s,
                                   "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                   fld[0], fld[1], fld[2], fld[3],
                                   fld[4], fld[5], fld[6], fld[7], fld[8], fld[9],
                                   fld[10], fld[11], fld[12], fld[13], fld[14],
                                   fld[15], fld[16], fld[17]);
                if (line_s.len() > 0 && line_s[0] != "#" && n_fields > 0) begin
                    if (n_fields != NUM_FIELDS) begin
                        err_cnt++;
                        $display("Error: stimulus line %0d has %0d fields instead of %0d",
                                 line_no, n_fields, NUM_FIELDS);
                    end else begin
                        if (fld[0][0]) begin
                            n_idle = int'($urandom % 3);
                            for (int i = 0; i < n_idle; i++) begin
                                idle_cycle();
                            end
                        end
                        line_cycle();
                        data_cnt++;
                    end
                end
            end
            $fclose(fd);
            idle_cycle();   // Checks the last line
            if (data_cnt == 0) begin
                err_cnt++;
                $display("Error: no stimulus lines were read from %s", STIM_FILE);
            end
        end

        $display("Summary: %0d lines, %0d checks, %0d errors", data_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* thread_ctrl_stimulus.txt */
# idle_ok create kill slp wake act obj init_pc atomic pc_wr pc_wr_trd nxt_pc
#   then expected after the edge: valid run cur_trd cur_pc trd_of invalid_op
# Thread 0 creates seven children, scheduler held, then one create too many
1 1 0 0 0 0 0 00020100 1 0 0 00000000 03 03 0 00010100 0 0
1 1 0 0 0 0 0 00020200 1 0 0 00000000 07 07 0 00010100 0 0
1 1 0 0 0 0 0 00020300 1 0 0 00000000 0f 0f 0 00010100 0 0
1 1 0 0 0 0 0 00020400 1 0 0 00000000 1f 1f 0 00010100 0 0
1 1 0 0 0 0 0 00020500 1 0 0 00000000 3f 3f 0 00010100 0 0
1 1 0 0 0 0 0 00020600 1 0 0 00000000 7f 7f 0 00010100 0 0
1 1 0 0 0 0 0 00020700 1 0 0 00000000 ff ff 0 00010100 0 0
1 1 0 0 0 0 0 00020800 1 0 0 00000000 ff ff 0 00010100 1 0
# Round robin over all eight, atomic hold on 3, PC write to thread 6
0 0 0 0 0 0 0 00000000 0 0 0 00000000 ff ff 1 00020100 0 0
0 0 0 0 0 0 0 00000000 0 0 0 00000000 ff ff 2 00020200 0 0
0 0 0 0 0 0 0 00000000 0 0 0 00000000 ff ff 3 00020300 0 0
0 0 0 0 0 0 0 00000000 1 0 0 00000000 ff ff 3 00020300 0 0
0 0 0 0 0 0 0 00000000 1 0 0 00000000 ff ff 3 00020300 0 0
0 0 0 0 0 0 0 00000000 0 0 0 00000000 ff ff 4 00020400 0 0
0 0 0 0 0 0 0 00000000 0 1 6 0000abc0 ff ff 5 00020500 0 0
0 0 0 0 0 0 0 00000000 0 0 0 00000000 ff ff 6 0000abc0 0 0
0 0 0 0 0 0 0 00000000 0 0 0 00000000 ff ff 7 00020700 0 0
0 0 0 0 0 0 0 00000000 0 0 0 00000000 ff ff 0 00010100 0 0
# Parent sleeps thread 2, scheduler skips it, then wakes it
0 0 0 1 0 0 2 00000000 0 0 0 00000000 ff fb 1 00020100 0 0
0 0 0 0 0 0 0 00000000 0 0 0 00000000 ff fb 3 00020300 0 0
0 0 0 0 1 0 2 00000000 1 0 0 00000000 ff ff 3 00020300 0 0
0 0 0 0 0 0 0 00000000 0 0 0 00000000 ff ff 4 00020400 0 0
# Sibling kill, child sleeping its parent, sibling wake are all refused
1 0 1 0 0 3 5 00000000 1 0 0 00000000 ff ff 4 00020400 0 1
1 0 0 1 0 1 0 00000000 1 0 0 00000000 ff ff 4 00020400 0 1
1 0 0 0 1 6 7 00000000 1 0 0 00000000 ff ff 4 00020400 0 1
# Kill 3 by parent, 1 kills itself, thread 4 refills slots 1 and 3
1 0 1 0 0 0 3 00000000 1 0 0 00000000 f7 f7 4 00020400 0 0
1 0 1 0 0 1 1 00000000 1 0 0 00000000 f5 f5 4 00020400 0 0
1 1 0 0 0 4 0 00030000 1 1 1 0000dead f7 f7 4 00020400 0 0
1 1 0 0 0 4 0 00031000 1 0 0 00000000 ff ff 4 00020400 0 0
# New parent 4 sleeps thread 3, one full turn of the scheduler
0 0 0 1 0 4 3 00000000 0 0 0 00000000 ff f7 5 00020500 0 0
0 0 0 0 0 0 0 00000000 0 0 0 00000000 ff f7 6 0000abc0 0 0
0 0 0 0 0 0 0 00000000 0 0 0 00000000 ff f7 7 00020700 0 0
0 0 0 0 0 0 0 00000000 0 0 0 00000000 ff f7 0 00010100 0 0
0 0 0 0 0 0 0 00000000 0 0 0 00000000 ff f7 1 00030000 0 0
0 0 0 0 0 0 0 00000000 0 0 0 00000000 ff f7 2 00020200 0 0
0 0 0 0 0 0 0 00000000 0 0 0 00000000 ff f7 4 00020400 0 0
# Old parent can no longer wake 3, the new one can
1 0 0 0 1 0 3 00000000 1 0 0 00000000 ff f7 4 00020400 0 1
1 0 0 0 1 4 3 00000000 1 0 0 00000000 ff ff 4 00020400 0 0

/* thread_ctrl.f */
thread_pkg.sv
thread_table.sv
thread_pc_file.sv
thread_sched.sv
thread_ctrl.sv
thread_ctrl_props.sv
tb_thread_ctrl.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the thread controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_thread_ctrl -f thread_ctrl.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/Vtb_thread_ctrl)"
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTS PASSED" <<< "$output"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
